//--- logic/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// datapath and address width, one word
`define XLEN 64
// register file address width
`define REG_AW 5
// instruction width
`define INST_W 32

// quotient bits produced per divide
`define DIV_STEPS `XLEN

// link address step
`define PC_STEP 4

`endif

//--- logic/ex_pkg.sv
`include "ex_params.svh"

package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [3:0] {
        BRU_NONE, BRU_JAL, BRU_JALR, BRU_BEQ, BRU_BNE,
        BRU_BLT, BRU_BGE, BRU_BLTU, BRU_BGEU
    } bru_op_e;

    typedef enum logic [1:0] {LSU_B, LSU_H, LSU_W, LSU_D} lsu_size_e;

    typedef enum logic [2:0] {DIV_NONE, DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_e;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_PC, SRC1_ZERO} src1_sel_e;

    typedef enum logic [2:0] {
        SRC2_RS2, SRC2_IMM_I, SRC2_IMM_U, SRC2_IMM_S, SRC2_FOUR
    } src2_sel_e;

    // iterative divider sequencing
    typedef enum logic [1:0] {IDLE, RUN, FIX, DONE} div_state_e;

    // immediates, all sign-extended to XLEN
    function automatic logic [`XLEN-1:0] imm_i(input logic [`INST_W-1:0] inst);
        return {{(`XLEN-12){inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [`XLEN-1:0] imm_s(input logic [`INST_W-1:0] inst);
        return {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    function automatic logic [`XLEN-1:0] imm_b(input logic [`INST_W-1:0] inst);
        return {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [`XLEN-1:0] imm_u(input logic [`INST_W-1:0] inst);
        return {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    endfunction

    function automatic logic [`XLEN-1:0] imm_j(input logic [`INST_W-1:0] inst);
        return {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

//--- logic/div_if.sv
`timescale 1ns/1ps
`include "ex_params.svh"

// four-phase req/ack link between the stage and its divider
interface div_if;

    logic              req;
    logic [`XLEN-1:0]  dividend;
    logic [`XLEN-1:0]  divisor;
    logic              is_signed;
    logic              is_rem;     // remainder instead of quotient
    logic              w32;        // word form, low 32 bits
    logic              ack;
    logic [`XLEN-1:0]  result;

    modport requester (
        output req, dividend, divisor, is_signed, is_rem, w32,
        input  ack, result
    );

    modport divider (
        input  req, dividend, divisor, is_signed, is_rem, w32,
        output ack, result
    );

endinterface

//--- logic/alu.sv
`timescale 1ns/1ps
`include "ex_params.svh"

module alu (
    input  ex_pkg::alu_op_e    op_i,
    input  logic [`XLEN-1:0]   a_i,
    input  logic [`XLEN-1:0]   b_i,
    input  logic               w32_i,
    output logic [`XLEN-1:0]   y_o
);
    import ex_pkg::*;

    logic [5:0]         shamt;
    logic [`XLEN-1:0]   sh_src;
    logic [`XLEN-1:0]   raw;

    assign shamt = w32_i ? {1'b0, b_i[4:0]} : b_i[5:0];

    // right shifts in W form see only the low word
    always_comb begin
        if (!w32_i) begin
            sh_src = a_i;
        end else if (op_i == ALU_SRA) begin
            sh_src = {{(`XLEN-32){a_i[31]}}, a_i[31:0]};
        end else begin
            sh_src = {{(`XLEN-32){1'b0}}, a_i[31:0]};
        end
    end

    always_comb begin
        case (op_i)
            ALU_ADD:  raw = a_i + b_i;
            ALU_SUB:  raw = a_i - b_i;
            ALU_SLL:  raw = a_i << shamt;
            ALU_SLT:  raw = {{(`XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: raw = {{(`XLEN-1){1'b0}}, a_i < b_i};
            ALU_XOR:  raw = a_i ^ b_i;
            ALU_SRL:  raw = sh_src >> shamt;
            ALU_SRA:  raw = $signed(sh_src) >>> shamt;
            ALU_OR:   raw = a_i | b_i;
            ALU_AND:  raw = a_i & b_i;
            default:  raw = '0;
        endcase
    end

    // W results are the low word sign-extended
    assign y_o = w32_i ? {{(`XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

//--- logic/branch_unit.sv
`timescale 1ns/1ps
`include "ex_params.svh"

module branch_unit (
    input  ex_pkg::bru_op_e    op_i,
    input  logic [`XLEN-1:0]   pc_i,
    input  logic [`XLEN-1:0]   rs1_i,
    input  logic [`XLEN-1:0]   rs2_i,
    input  logic [`INST_W-1:0] inst_i,
    output logic               taken_o,
    output logic [`XLEN-1:0]   target_o
);
    import ex_pkg::*;

    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic [`XLEN-1:0]   br_tgt;
    logic [`XLEN-1:0]   jalr_sum;

    assign eq       = (rs1_i == rs2_i);
    assign lt_s     = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u     = rs1_i < rs2_i;
    assign br_tgt   = pc_i + imm_b(inst_i);
    assign jalr_sum = rs1_i + imm_i(inst_i);

    always_comb begin
        taken_o  = 1'b0;
        target_o = br_tgt;
        case (op_i)
            BRU_JAL: begin
                taken_o  = 1'b1;
                target_o = pc_i + imm_j(inst_i);
            end
            BRU_JALR: begin
                taken_o  = 1'b1;
                target_o = {jalr_sum[`XLEN-1:1], 1'b0};  // lsb forced clear
            end
            BRU_BEQ:  taken_o = eq;
            BRU_BNE:  taken_o = !eq;
            BRU_BLT:  taken_o = lt_s;
            BRU_BGE:  taken_o = !lt_s;
            BRU_BLTU: taken_o = lt_u;
            BRU_BGEU: taken_o = !lt_u;
            default:  target_o = '0;    // no branch
        endcase
    end

endmodule

//--- logic/lsu_format.sv
`timescale 1ns/1ps
`include "ex_params.svh"

module lsu_format (
    input  logic               en_i,
    input  logic               store_i,
    input  ex_pkg::lsu_size_e  size_i,
    input  logic [2:0]         addr_low_i,
    input  logic [`XLEN-1:0]   rs2_i,
    output logic [`XLEN-1:0]   wdata_o,
    output logic [7:0]         sel_o
);
    import ex_pkg::*;

    logic [7:0] run;    // size-many ones
    logic [2:0] base;   // offset aligned down to the size

    always_comb begin
        case (size_i)
            LSU_B: begin
                run     = 8'h01;
                base    = addr_low_i;
                wdata_o = {8{rs2_i[7:0]}};
            end
            LSU_H: begin
                run     = 8'h03;
                base    = {addr_low_i[2:1], 1'b0};
                wdata_o = {4{rs2_i[15:0]}};
            end
            LSU_W: begin
                run     = 8'h0f;
                base    = {addr_low_i[2], 2'b00};
                wdata_o = {2{rs2_i[31:0]}};
            end
            default: begin
                run     = 8'hff;
                base    = 3'd0;
                wdata_o = rs2_i;
            end
        endcase
        if (!store_i) begin
            wdata_o = '0;
        end
    end

    assign sel_o = en_i ? (run << base) : 8'h00;

endmodule

//--- logic/div_iter.sv
`timescale 1ns/1ps
`include "ex_params.svh"

// radix-2 restoring divider, one quotient bit per cycle
module div_iter (
    input logic     clk,
    input logic     rst,
    div_if.divider  dif
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(`DIV_STEPS);

    div_state_e         state;
    logic [CNT_W-1:0]   cnt;
    logic               ack_q;
    logic [`XLEN-1:0]   quo_q;   // dividend shifts out, quotient shifts in
    logic [`XLEN-1:0]   rem_q;
    logic [`XLEN-1:0]   dvs_q;
    logic [`XLEN-1:0]   res_q;

    logic [`XLEN-1:0]   a_ext;
    logic [`XLEN-1:0]   b_ext;
    logic [`XLEN-1:0]   int_min;
    logic               sign_a;
    logic               sign_b;
    logic               ovf;
    logic [`XLEN:0]     rem_sh;
    logic [`XLEN:0]     diff;
    logic               ge;
    logic [`XLEN-1:0]   q_fin;
    logic [`XLEN-1:0]   r_fin;
    logic [`XLEN-1:0]   res_fin;

    // word forms widen the low word by the sign rule
    always_comb begin
        a_ext = dif.dividend;
        b_ext = dif.divisor;
        if (dif.w32) begin
            a_ext = {{(`XLEN-32){dif.is_signed & dif.dividend[31]}}, dif.dividend[31:0]};
            b_ext = {{(`XLEN-32){dif.is_signed & dif.divisor[31]}}, dif.divisor[31:0]};
        end
    end

    assign sign_a  = dif.is_signed & a_ext[`XLEN-1];
    assign sign_b  = dif.is_signed & b_ext[`XLEN-1];
    assign int_min = dif.w32 ? {{(`XLEN-31){1'b1}}, 31'b0} : {1'b1, {(`XLEN-1){1'b0}}};
    assign ovf     = sign_a & (&b_ext) & (a_ext == int_min);

    // one restoring step
    assign rem_sh = {rem_q, quo_q[`XLEN-1]};
    assign diff   = rem_sh - {1'b0, dvs_q};
    assign ge     = rem_sh >= {1'b0, dvs_q};

    always_comb begin
        q_fin = (sign_a ^ sign_b) ? -quo_q : quo_q;
        r_fin = sign_a ? -rem_q : rem_q;
        if (b_ext == '0) begin
            q_fin = '1;
            r_fin = a_ext;
        end else if (ovf) begin
            q_fin = a_ext;
            r_fin = '0;
        end
        res_fin = dif.is_rem ? r_fin : q_fin;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
            ack_q <= 1'b0;
        end else begin
            case (state)
                IDLE: if (dif.req) begin   // load cycle
                    state <= RUN;
                    cnt   <= '0;
                end
                RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`DIV_STEPS - 1)) state <= FIX;
                end
                FIX: begin
                    state <= DONE;
                    ack_q <= 1'b1;
                end
                default: if (!dif.req) begin   // requester took the result
                    state <= IDLE;
                    ack_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                quo_q <= sign_a ? -a_ext : a_ext;
                rem_q <= '0;
                dvs_q <= sign_b ? -b_ext : b_ext;
            end
            RUN: begin
                quo_q <= {quo_q[`XLEN-2:0], ge};
                rem_q <= ge ? diff[`XLEN-1:0] : rem_sh[`XLEN-1:0];
            end
            FIX: res_q <= dif.w32 ? {{(`XLEN-32){res_fin[31]}}, res_fin[31:0]} : res_fin;
            default: begin
            end
        endcase
    end

    assign dif.ack    = ack_q;
    assign dif.result = res_q;

endmodule

//--- logic/ex_stage.sv
`timescale 1ns/1ps
`include "ex_params.svh"

module ex_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                hold_i,
    input  logic                flush_i,
    input  logic                valid_i,
    input  ex_pkg::alu_op_e     alu_op_i,
    input  ex_pkg::bru_op_e     bru_op_i,
    input  ex_pkg::div_op_e     div_op_i,
    input  ex_pkg::src1_sel_e   src1_sel_i,
    input  ex_pkg::src2_sel_e   src2_sel_i,
    input  logic                w32_i,
    input  logic                load_i,
    input  logic                store_i,
    input  ex_pkg::lsu_size_e   lsu_size_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  logic [`XLEN-1:0]    next_pc_i,
    input  logic [`XLEN-1:0]    rs1_data_i,
    input  logic [`XLEN-1:0]    rs2_data_i,
    input  logic [`INST_W-1:0]  inst_i,
    input  logic [`REG_AW-1:0]  rd_i,
    input  logic                rf_we_i,
    output logic                stall_o,
    output logic [`XLEN-1:0]    result_o,
    output logic [`REG_AW-1:0]  rd_o,
    output logic                rf_we_o,
    output logic                mem_en_o,
    output logic                mem_we_o,
    output logic [`XLEN-1:0]    mem_addr_o,
    output logic [`XLEN-1:0]    mem_wdata_o,
    output logic [7:0]          mem_sel_o,
    output logic                br_taken_o,
    output logic [`XLEN-1:0]    br_target_o,
    output logic [`XLEN-1:0]    npc_o,
    output logic [`XLEN-1:0]    ex_pc_o
);
    import ex_pkg::*;

    // stage register
    logic               valid_q;
    logic               done_q;    // divide result captured
    alu_op_e            alu_op_q;
    bru_op_e            bru_op_q;
    div_op_e            div_op_q;
    src1_sel_e          src1_sel_q;
    src2_sel_e          src2_sel_q;
    lsu_size_e          lsu_size_q;
    logic               w32_q;
    logic               load_q;
    logic               store_q;
    logic               rf_we_q;
    logic [`XLEN-1:0]   pc_q;
    logic [`XLEN-1:0]   next_pc_q;
    logic [`XLEN-1:0]   rs1_q;
    logic [`XLEN-1:0]   rs2_q;
    logic [`INST_W-1:0] inst_q;
    logic [`REG_AW-1:0] rd_q;
    logic [`XLEN-1:0]   div_res_q;

    logic [`XLEN-1:0]   src1;
    logic [`XLEN-1:0]   src2;
    logic [`XLEN-1:0]   alu_y;
    logic               br_taken;
    logic               is_div;

    div_if dbus ();

    // stall outranks flush, flush outranks hold
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else if (stall_o) begin
            if (dbus.ack) done_q <= 1'b1;
        end else if (flush_i) begin
            valid_q <= 1'b0;   // bubble
            done_q  <= 1'b0;
        end else if (!hold_i) begin
            valid_q <= valid_i;
            done_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o && !flush_i && !hold_i) begin
            alu_op_q   <= alu_op_i;
            bru_op_q   <= bru_op_i;
            div_op_q   <= div_op_i;
            src1_sel_q <= src1_sel_i;
            src2_sel_q <= src2_sel_i;
            lsu_size_q <= lsu_size_i;
            w32_q      <= w32_i;
            load_q     <= load_i;
            store_q    <= store_i;
            rf_we_q    <= rf_we_i;
            pc_q       <= pc_i;
            next_pc_q  <= next_pc_i;
            rs1_q      <= rs1_data_i;
            rs2_q      <= rs2_data_i;
            inst_q     <= inst_i;
            rd_q       <= rd_i;
        end
        if (stall_o && dbus.ack) div_res_q <= dbus.result;
    end

    always_comb begin
        case (src1_sel_q)
            SRC1_PC:   src1 = pc_q;
            SRC1_ZERO: src1 = '0;
            default:   src1 = rs1_q;
        endcase
        case (src2_sel_q)
            SRC2_IMM_I: src2 = imm_i(inst_q);
            SRC2_IMM_U: src2 = imm_u(inst_q);
            SRC2_IMM_S: src2 = imm_s(inst_q);
            SRC2_FOUR:  src2 = `XLEN'(`PC_STEP);   // link address
            default:    src2 = rs2_q;
        endcase
    end

    // divide request stays up until the result is captured
    assign is_div         = valid_q && (div_op_q != DIV_NONE);
    assign dbus.req       = is_div && !done_q;
    assign dbus.dividend  = rs1_q;
    assign dbus.divisor   = rs2_q;
    assign dbus.is_signed = (div_op_q == DIV_DIV) || (div_op_q == DIV_REM);
    assign dbus.is_rem    = (div_op_q == DIV_REM) || (div_op_q == DIV_REMU);
    assign dbus.w32       = w32_q;
    assign stall_o        = dbus.req;

    alu u_alu (.op_i(alu_op_q), .a_i(src1), .b_i(src2), .w32_i(w32_q), .y_o(alu_y));

    branch_unit u_bru (
        .op_i     (bru_op_q),
        .pc_i     (pc_q),
        .rs1_i    (rs1_q),
        .rs2_i    (rs2_q),
        .inst_i   (inst_q),
        .taken_o  (br_taken),
        .target_o (br_target_o)
    );

    lsu_format u_lsu (
        .en_i       (mem_en_o),
        .store_i    (mem_we_o),
        .size_i     (lsu_size_q),
        .addr_low_i (alu_y[2:0]),
        .rs2_i      (rs2_q),
        .wdata_o    (mem_wdata_o),
        .sel_o      (mem_sel_o)
    );

    div_iter u_div (.clk(clk), .rst(rst), .dif(dbus.divider));

    assign result_o   = is_div ? div_res_q : alu_y;
    assign rd_o       = rd_q;
    assign rf_we_o    = valid_q && rf_we_q && (rd_q != '0);   // x0 never written
    assign mem_en_o   = valid_q && (load_q || store_q);
    assign mem_we_o   = valid_q && store_q;
    assign mem_addr_o = alu_y;
    assign br_taken_o = valid_q && br_taken;
    assign npc_o      = br_taken_o ? br_target_o : next_pc_q;
    assign ex_pc_o    = pc_q;

endmodule

//--- bench/ex_stage_props.sv
`timescale 1ns/1ps

// handshake and output rules of the execute stage
module ex_stage_props (
    input logic       clk,
    input logic       rst,
    input logic       stall_i,
    input logic       req_i,
    input logic       ack_i,
    input logic       mem_en_i,
    input logic [7:0] mem_sel_i
);

    a_stall_after_rst: assert property (@(posedge clk) rst |=> !stall_i)
        else $error("stall high right after reset");

    // req may only drop once ack is seen
    a_req_held: assert property (@(posedge clk) disable iff (rst) req_i && !ack_i |=> req_i)
        else $error("divide request dropped before ack");

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack_i) |-> req_i)
        else $error("ack raised with no request");

    a_sel_idle: assert property (@(posedge clk) !mem_en_i |-> mem_sel_i == 8'h00)
        else $error("byte enables active with memory idle");

endmodule

bind ex_stage ex_stage_props u_props (
    .clk       (clk),
    .rst       (rst),
    .stall_i   (stall_o),
    .req_i     (dbus.req),
    .ack_i     (dbus.ack),
    .mem_en_i  (mem_en_o),
    .mem_sel_i (mem_sel_o)
);

//--- bench/tb_ex_stage.sv
`timescale 1ns/1ps
`include "ex_params.svh"

module tb_ex_stage;
    import ex_pkg::*;

    localparam logic [`XLEN-1:0] PC   = 64'h1000;
    localparam logic [`XLEN-1:0] NPC  = 64'h1004;
    localparam logic [`XLEN-1:0] BTGT = 64'h1010;   // PC plus B immediate 16 of 32'h800

    typedef struct packed {
        alu_op_e            alu;
        bru_op_e            bru;
        div_op_e            dv;
        src1_sel_e          s1;
        src2_sel_e          s2;
        logic               w32;
        logic               ld;
        logic               st;
        lsu_size_e          sz;
        logic [`XLEN-1:0]   rs1;
        logic [`XLEN-1:0]   rs2;
        logic [`INST_W-1:0] inst;
        logic [`REG_AW-1:0] rd;
        logic [1:0]         ctl;    // 0 normal, 1 flush, 2 hold
        logic [`XLEN-1:0]   res;
        logic               tk;
        logic [`XLEN-1:0]   npc;
        logic [7:0]         sel;
        logic [`XLEN-1:0]   wd;
    } entry_t;

    logic clk, rst, hold_i, flush_i, valid_i, w32_i, load_i, store_i, rf_we_i;
    alu_op_e alu_op_i;
    bru_op_e bru_op_i;
    div_op_e div_op_i;
    src1_sel_e src1_sel_i;
    src2_sel_e src2_sel_i;
    lsu_size_e lsu_size_i;
    logic [`XLEN-1:0] pc_i, next_pc_i, rs1_data_i, rs2_data_i;
    logic [`INST_W-1:0] inst_i;
    logic [`REG_AW-1:0] rd_i;
    logic stall_o, rf_we_o, mem_en_o, mem_we_o, br_taken_o;
    logic [`XLEN-1:0] result_o, mem_addr_o, mem_wdata_o, br_target_o, npc_o, ex_pc_o;
    logic [`REG_AW-1:0] rd_o;
    logic [7:0] mem_sel_o;

    entry_t tbl[$];
    int errors = 0;
    int cycles = 0;
    int limit = 0;
    integer seed = 40;

    ex_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add(input alu_op_e alu, input bru_op_e bru, input div_op_e dv,
                       input src1_sel_e s1, input src2_sel_e s2, input logic w32,
                       input logic ld, input logic st, input lsu_size_e sz,
                       input logic [`XLEN-1:0] rs1, input logic [`XLEN-1:0] rs2,
                       input logic [`INST_W-1:0] inst, input logic [`REG_AW-1:0] rd,
                       input logic [1:0] ctl, input logic [`XLEN-1:0] res, input logic tk,
                       input logic [`XLEN-1:0] npc, input logic [7:0] sel,
                       input logic [`XLEN-1:0] wd);
        tbl.push_back({alu, bru, dv, s1, s2, w32, ld, st, sz, rs1, rs2, inst, rd, ctl,
                       res, tk, npc, sel, wd});
    endtask

    task automatic add_alu(input alu_op_e op, input src1_sel_e s1, input src2_sel_e s2,
                           input logic w32, input logic [`XLEN-1:0] a,
                           input logic [`XLEN-1:0] b, input logic [`INST_W-1:0] inst,
                           input logic [`XLEN-1:0] res);
        add(op, BRU_NONE, DIV_NONE, s1, s2, w32, 0, 0, LSU_D, a, b, inst, 5, 0,
            res, 0, NPC, 0, 0);
    endtask

    task automatic add_br(input bru_op_e op, input logic [`XLEN-1:0] a,
                          input logic [`XLEN-1:0] b, input logic [`INST_W-1:0] inst,
                          input logic tk, input logic [`XLEN-1:0] npc);
        add(ALU_ADD, op, DIV_NONE, SRC1_PC, SRC2_FOUR, 0, 0, 0, LSU_D, a, b, inst, 1, 0,
            NPC, tk, npc, 0, 0);
    endtask

    task automatic add_div(input div_op_e op, input logic w32, input logic [`XLEN-1:0] a,
                           input logic [`XLEN-1:0] b, input logic [`XLEN-1:0] res);
        add(ALU_ADD, BRU_NONE, op, SRC1_RS1, SRC2_RS2, w32, 0, 0, LSU_D, a, b, 0, 7, 0,
            res, 0, NPC, 0, 0);
    endtask

    // RISC-V divide rules, computed on signed and unsigned integers
    function automatic logic [`XLEN-1:0] ref_div(input div_op_e op, input logic w,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        logic signed [`XLEN-1:0] sa, sb, smin, sq, sr;
        logic [`XLEN-1:0] ua, ub, r;
        sa   = w ? {{32{a[31]}}, a[31:0]} : a;
        sb   = w ? {{32{b[31]}}, b[31:0]} : b;
        ua   = w ? {32'h0, a[31:0]} : a;
        ub   = w ? {32'h0, b[31:0]} : b;
        smin = w ? 64'hffffffff80000000 : 64'h8000000000000000;
        sq   = '0;
        sr   = '0;
        if (sb != 0 && !(sa == smin && sb == -1)) begin
            sq = sa / sb;   // signed quotient, truncated toward zero
            sr = sa % sb;
        end
        case (op)
            DIV_DIV:  r = (sb == 0) ? '1 : (sa == smin && sb == -1) ? sa : sq;
            DIV_REM:  r = (sb == 0) ? sa : (sa == smin && sb == -1) ? '0 : sr;
            DIV_DIVU: r = (ub == 0) ? '1 : ua / ub;
            default:  r = (ub == 0) ? ua : ua % ub;
        endcase
        return w ? {{32{r[31]}}, r[31:0]} : r;
    endfunction

    // low n bytes of v repeated over all lanes
    function automatic logic [`XLEN-1:0] repl(input int n, input logic [`XLEN-1:0] v);
        logic [`XLEN-1:0] w;
        for (int i = 0; i < 8; i++) w[i*8 +: 8] = v[(i % n)*8 +: 8];
        return w;
    endfunction

    task automatic build_table();
        logic [`XLEN-1:0] a, b, d;
        int n;
        d = 64'h1122334455667788;
        add_alu(ALU_ADD, SRC1_RS1, SRC2_RS2, 0, 5, 7, 0, 64'hc);
        add(ALU_SUB, BRU_NONE, DIV_NONE, SRC1_RS1, SRC2_RS2, 0, 0, 0, LSU_D, 5, 7, 0, 5, 2,
            64'hc, 0, NPC, 0, 0);   // held, keeps the ADD result
        add_alu(ALU_SUB, SRC1_RS1, SRC2_RS2, 0, 5, 7, 0, 64'hfffffffffffffffe);
        add_alu(ALU_SLL, SRC1_RS1, SRC2_RS2, 0, 1, 64'h43, 0, 64'h8);
        add_alu(ALU_SLT, SRC1_RS1, SRC2_RS2, 0, '1, 1, 0, 64'h1);
        add_alu(ALU_SLTU, SRC1_RS1, SRC2_RS2, 0, '1, 1, 0, 64'h0);
        add_alu(ALU_XOR, SRC1_RS1, SRC2_RS2, 0, 64'hf0f0, 64'hff00, 0, 64'h0ff0);
        add_alu(ALU_SRL, SRC1_RS1, SRC2_RS2, 0, 64'h8000000000000000, 4, 0,
                64'h0800000000000000);
        add_alu(ALU_SRA, SRC1_RS1, SRC2_RS2, 0, 64'h8000000000000000, 4, 0,
                64'hf800000000000000);
        add_alu(ALU_OR, SRC1_RS1, SRC2_RS2, 0, 64'hf0, 64'h0f, 0, 64'hff);
        add_alu(ALU_AND, SRC1_RS1, SRC2_RS2, 0, 64'hf0, 64'h3c, 0, 64'h30);
        add_alu(ALU_ADD, SRC1_RS1, SRC2_RS2, 1, 64'h7fffffff, 1, 0, 64'hffffffff80000000);
        add_alu(ALU_SLL, SRC1_RS1, SRC2_RS2, 1, 1, 64'h3f, 0, 64'hffffffff80000000);
        add_alu(ALU_SRL, SRC1_RS1, SRC2_RS2, 1, 64'hffffffff80000000, 4, 0, 64'h08000000);
        add_alu(ALU_SRA, SRC1_RS1, SRC2_RS2, 1, 64'hffffffff80000000, 4, 0,
                64'hfffffffff8000000);
        add_alu(ALU_SUB, SRC1_RS1, SRC2_RS2, 1, 0, 1, 0, '1);
        add_alu(ALU_ADD, SRC1_PC, SRC2_FOUR, 0, 0, 0, 0, 64'h1004);
        add_alu(ALU_ADD, SRC1_ZERO, SRC2_IMM_U, 0, 9, 0, 32'h12345000, 64'h12345000);
        add_alu(ALU_ADD, SRC1_ZERO, SRC2_IMM_U, 0, 9, 0, 32'h80000000, 64'hffffffff80000000);
        add_alu(ALU_ADD, SRC1_RS1, SRC2_IMM_I, 0, 64'h10, 0, 32'hfff00000, 64'hf);
        add_alu(ALU_ADD, SRC1_RS1, SRC2_IMM_S, 0, 64'h10, 0, 32'h00000180, 64'h13);
        add(ALU_ADD, BRU_NONE, DIV_NONE, SRC1_RS1, SRC2_RS2, 0, 0, 0, LSU_D, 5, 7, 0, 0, 0,
            64'hc, 0, NPC, 0, 0);   // rd is x0
        add_br(BRU_BEQ, 3, 3, 32'h800, 1, 64'h1010);
        add_br(BRU_BEQ, 3, 4, 32'h800, 0, NPC);
        add_br(BRU_BNE, 3, 4, 32'h800, 1, 64'h1010);
        add_br(BRU_BNE, 3, 3, 32'h800, 0, NPC);
        add_br(BRU_BLT, '1, 1, 32'h800, 1, 64'h1010);
        add_br(BRU_BLT, 1, '1, 32'h800, 0, NPC);
        add_br(BRU_BGE, 1, '1, 32'h800, 1, 64'h1010);
        add_br(BRU_BGE, '1, 1, 32'h800, 0, NPC);
        add_br(BRU_BLTU, 1, '1, 32'h800, 1, 64'h1010);
        add_br(BRU_BLTU, '1, 1, 32'h800, 0, NPC);
        add_br(BRU_BGEU, '1, 1, 32'h800, 1, 64'h1010);
        add_br(BRU_BGEU, 1, '1, 32'h800, 0, NPC);
        add_br(BRU_JAL, 0, 0, 32'h02000000, 1, 64'h1020);
        add_br(BRU_JALR, 64'h2001, 0, 32'h00800000, 1, 64'h2008);
        for (int st = 0; st < 2; st++) begin
            for (int s = 0; s < 4; s++) begin
                n = 1 << s;
                for (int off = 0; off < 8; off += n) begin
                    add(ALU_ADD, BRU_NONE, DIV_NONE, SRC1_RS1, SRC2_IMM_S, 0, !st, st,
                        lsu_size_e'(s), 64'h100 + off, d, 0, 3, 0, 64'h100 + off, 0, NPC,
                        (8'hff >> (8 - n)) << off, st ? repl(n, d) : '0);
                end
            end
        end
        add(ALU_ADD, BRU_NONE, DIV_NONE, SRC1_RS1, SRC2_IMM_S, 0, 0, 1, LSU_W, 0, d, 0, 3, 1,
            0, 0, NPC, 0, 0);   // flushed store
        add_div(DIV_DIV, 0, 20, -3, -6);
        add_div(DIV_REM, 0, 20, -3, 2);
        add_div(DIV_DIVU, 0, 20, 3, 6);
        add_div(DIV_REMU, 0, 20, 3, 2);
        add_div(DIV_DIV, 0, 20, 0, '1);
        add_div(DIV_REM, 0, 20, 0, 20);
        add_div(DIV_DIV, 0, 64'h8000000000000000, '1, 64'h8000000000000000);
        add_div(DIV_REM, 0, 64'h8000000000000000, '1, 0);
        add_div(DIV_DIV, 1, 64'hffffffff80000000, '1, 64'hffffffff80000000);
        add_div(DIV_REM, 1, 64'hffffffff80000000, '1, 0);
        add_div(DIV_DIVU, 1, 64'hffffffff, 2, 64'h7fffffff);
        add_div(DIV_REMU, 1, 64'h12345678fffffff0, 0, 64'hfffffffffffffff0);
        add_div(DIV_DIV, 1, 64'h5, 0, '1);
        for (int i = 0; i < 8; i++) begin
            a = {$random(seed), $random(seed)};
            b = (i % 3 == 0) ? {32'h0, $random(seed)} : {$random(seed), $random(seed)};
            add_div(div_op_e'(1 + i % 4), i[0], a, b, ref_div(div_op_e'(1 + i % 4), i[0], a, b));
        end
    endtask

    task automatic drive(input entry_t e);
        alu_op_i   = e.alu;
        bru_op_i   = e.bru;
        div_op_i   = e.dv;
        src1_sel_i = e.s1;
        src2_sel_i = e.s2;
        w32_i      = e.w32;
        load_i     = e.ld;
        store_i    = e.st;
        lsu_size_i = e.sz;
        rs1_data_i = e.rs1;
        rs2_data_i = e.rs2;
        inst_i     = e.inst;
        rd_i       = e.rd;
        flush_i    = (e.ctl == 1);
        hold_i     = (e.ctl == 2);
    endtask

    initial begin
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the stage never finished", cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        entry_t e;
        int err0;
        logic saw_stall;
        rst     = 1'b1;
        valid_i = 1'b1;
        rf_we_i = 1'b1;
        pc_i      = PC;
        next_pc_i = NPC;
        drive('0);
        build_table();
        limit = tbl.size() * (`DIV_STEPS + 10);
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        foreach (tbl[i]) begin
            e = tbl[i];
            err0 = errors;
            drive(e);
            @(posedge clk);
            #1 saw_stall = stall_o;
            while (stall_o) begin
                @(posedge clk);
                #1;
            end
            if (saw_stall !== (e.dv != DIV_NONE && e.ctl == 0)) begin
                $display("stall did not follow the divide rule in test %0d", i);
                errors++;
            end
            if (e.ctl != 1) begin
                check_val("result_o", result_o, e.res);
                check_val("br_taken_o", br_taken_o, e.tk);
                check_val("npc_o", npc_o, e.npc);
                check_val("br_target_o", br_target_o,
                          (e.bru == BRU_NONE) ? '0 : (e.tk ? e.npc : BTGT));
                check_val("mem_wdata_o", mem_wdata_o, e.wd);
                check_val("rd_o", rd_o, e.rd);
            end
            if ((e.ld || e.st) && e.ctl == 0) check_val("mem_addr_o", mem_addr_o, e.res);
            check_val("mem_sel_o", mem_sel_o, e.sel);
            check_val("rf_we_o", rf_we_o, e.ctl != 1 && e.rd != 0);
            check_val("mem_en_o", mem_en_o, e.ctl == 0 && (e.ld || e.st));
            check_val("mem_we_o", mem_we_o, e.ctl == 0 && e.st);
            check_val("ex_pc_o", ex_pc_o, PC);
            $display("test %0d %s", i, (errors == err0) ? "ok" : "failed");
        end
        $display("tests %0d, errors %0d", tbl.size(), errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/ex_pkg.sv
logic/div_if.sv
logic/alu.sv
logic/branch_unit.sv
logic/lsu_format.sv
logic/div_iter.sv
logic/ex_stage.sv
bench/ex_stage_props.sv
bench/tb_ex_stage.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_ex_stage \
    -o sim_ex_stage > build.log 2>&1 \
    && ./obj_dir/sim_ex_stage > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
